// File: build.f
+incdir+include
src/raster_pkg.sv
src/fill_counter.sv
src/line_stepper.sv
src/pixel_writer.sv
src/cmd_sequencer.sv
src/raster_top.sv
test/tb_raster.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the raster testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_raster \
    -f build.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_raster > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$SIM_LOG"; then
    exit 0
fi
exit 1

// File: src/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
    input  logic                          clk,
    input  logic                          reset_i,

    input  logic                          cmd_valid_i,
    output logic                          cmd_ready_o,
    input  logic [raster_pkg::CMD_W-1:0]  cmd_data_i,

    input  logic                          fill_done_i,
    input  logic                          line_done_i,
    output logic                          fill_start_o,
    output logic                          line_start_o,

    // endpoints stay put while a line is drawn
    output raster_pkg::coord_t            x0_o,
    output raster_pkg::coord_t            y0_o,
    output raster_pkg::coord_t            x1_o,
    output raster_pkg::coord_t            y1_o,
    output raster_pkg::pixel_t            color_o,

    output logic                          swap_o
);
    import raster_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FILLING,
        LINING
    } state_e;

    state_e           state;
    logic             accept;
    op_e              op;
    logic [ARG_W-1:0] arg;

    // only take commands while no operation is running
    assign cmd_ready_o = (state == IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;

    assign op  = op_e'(cmd_data_i[CMD_W-1 -: OP_W]);
    assign arg = cmd_data_i[ARG_W-1:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= IDLE;
            fill_start_o <= 1'b0;
            line_start_o <= 1'b0;
            swap_o       <= 1'b0;
            x0_o         <= '0;
            y0_o         <= '0;
            x1_o         <= '0;
            y1_o         <= '0;
            color_o      <= '0;
        end else begin
            // strobes last a single cycle
            fill_start_o <= 1'b0;
            line_start_o <= 1'b0;
            swap_o       <= 1'b0;

            case (state)
                IDLE: begin
                    if (accept) begin
                        case (op)
                            OP_SET_X0: x0_o <= arg;
                            OP_SET_Y0: y0_o <= arg;
                            OP_SET_X1: x1_o <= arg;
                            OP_SET_Y1: y1_o <= arg;
                            // 12-bit RGB, alpha forced opaque
                            OP_SET_COLOR: color_o <= {4'hF, arg};
                            OP_CLEAR: begin
                                fill_start_o <= 1'b1;
                                state        <= FILLING;
                            end
                            OP_DRAW_LINE: begin
                                line_start_o <= 1'b1;
                                state        <= LINING;
                            end
                            OP_SWAP: swap_o <= 1'b1;
                            default: ;
                        endcase
                    end
                end

                FILLING: begin
                    if (fill_done_i) begin
                        state <= IDLE;
                    end
                end

                LINING: begin
                    if (line_done_i) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // a done pulse must always belong to an operation we started
    a_no_done_in_idle: assert property (
        @(posedge clk) disable iff (reset_i)
        (state == IDLE) |-> !(fill_done_i || line_done_i)
    );

endmodule

// File: src/fill_counter.sv
`timescale 1ns/1ps

module fill_counter #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              start_i,
    output raster_pkg::addr_t addr_o,
    output logic              active_o,
    output logic              done_o
);
    import raster_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(FB_WIDTH * FB_HEIGHT - 1);

    // terminal count rides along with the last address
    assign done_o = active_o && (addr_o == LAST_ADDR);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_o <= 1'b0;
            addr_o   <= '0;
        end else if (start_i) begin
            active_o <= 1'b1;
            addr_o   <= '0;
        end else if (active_o) begin
            if (done_o) begin
                active_o <= 1'b0;
            end else begin
                addr_o <= addr_o + 1'b1;
            end
        end
    end

    // sequencer must wait for the sweep to finish before restarting
    a_no_restart: assert property (
        @(posedge clk) disable iff (reset_i)
        !(start_i && active_o)
    );

endmodule

// File: src/line_stepper.sv
`timescale 1ns/1ps

module line_stepper (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               start_i,
    input  raster_pkg::coord_t x0_i,
    input  raster_pkg::coord_t y0_i,
    input  raster_pkg::coord_t x1_i,
    input  raster_pkg::coord_t y1_i,
    output raster_pkg::coord_t x_o,
    output raster_pkg::coord_t y_o,
    output logic               drawing_o,
    output logic               done_o
);
    import raster_pkg::*;

    // error term needs headroom for the doubling
    localparam int ERR_W = COORD_W + 3;

    logic signed [ERR_W-1:0] diff_x;
    logic signed [ERR_W-1:0] diff_y;
    logic signed [ERR_W-1:0] abs_x;
    logic signed [ERR_W-1:0] abs_y;

    logic signed [ERR_W-1:0] dx;
    logic signed [ERR_W-1:0] dy;
    logic signed [ERR_W-1:0] err;
    logic signed [ERR_W-1:0] e2;
    logic signed [ERR_W-1:0] err_next;
    logic                    x_neg;
    logic                    y_neg;

    logic at_end;
    logic step_x;
    logic step_y;

    always_comb begin
        diff_x = ERR_W'(x1_i) - ERR_W'(x0_i);
        diff_y = ERR_W'(y1_i) - ERR_W'(y0_i);
        abs_x  = diff_x[ERR_W-1] ? -diff_x : diff_x;
        abs_y  = diff_y[ERR_W-1] ? -diff_y : diff_y;
    end

    // endpoint inputs are held by the sequencer for the whole line
    assign at_end = (x_o == x1_i) && (y_o == y1_i);
    assign done_o = drawing_o && at_end;

    always_comb begin
        e2       = err <<< 1;
        step_x   = (e2 >= dy);
        step_y   = (e2 <= dx);
        err_next = err;
        if (step_x) begin
            err_next = err_next + dy;
        end
        if (step_y) begin
            err_next = err_next + dx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            drawing_o <= 1'b0;
        end else if (start_i) begin
            drawing_o <= 1'b1;
            x_o       <= x0_i;
            y_o       <= y0_i;
            dx        <= abs_x;
            dy        <= -abs_y;
            x_neg     <= diff_x[ERR_W-1];
            y_neg     <= diff_y[ERR_W-1];
            err       <= abs_x - abs_y;
        end else if (drawing_o) begin
            if (at_end) begin
                drawing_o <= 1'b0;
            end else begin
                err <= err_next;
                if (step_x) begin
                    x_o <= x_neg ? x_o - 1 : x_o + 1;
                end
                if (step_y) begin
                    y_o <= y_neg ? y_o - 1 : y_o + 1;
                end
            end
        end
    end

    // a new line only starts once the previous one has finished
    a_no_start_while_drawing: assert property (
        @(posedge clk) disable iff (reset_i)
        !(start_i && drawing_o)
    );

endmodule

// File: src/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic               clk,
    input  logic               reset_i,

    input  logic               fill_active_i,
    input  raster_pkg::addr_t  fill_addr_i,

    input  logic               line_drawing_i,
    input  raster_pkg::coord_t line_x_i,
    input  raster_pkg::coord_t line_y_i,

    input  raster_pkg::pixel_t color_i,

    output logic               vram_wr_o,
    output raster_pkg::addr_t  vram_addr_o,
    output raster_pkg::pixel_t vram_data_o
);
    import raster_pkg::*;

    localparam int unsigned FB_SIZE = FB_WIDTH * FB_HEIGHT;

    logic  in_bounds;
    addr_t line_addr;

    // clip against the framebuffer, negative coordinates included
    assign in_bounds = (line_x_i >= 0) && (line_x_i < FB_WIDTH) &&
                       (line_y_i >= 0) && (line_y_i < FB_HEIGHT);

    // row-major linear address
    assign line_addr = addr_t'(line_y_i) * addr_t'(FB_WIDTH) + addr_t'(line_x_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_wr_o <= 1'b0;
        end else begin
            vram_wr_o <= fill_active_i || (line_drawing_i && in_bounds);
        end
    end

    always_ff @(posedge clk) begin
        vram_addr_o <= fill_active_i ? fill_addr_i : line_addr;
        vram_data_o <= color_i;
    end

    // clear and line never overlap, the sequencer runs one at a time
    a_one_source: assert property (
        @(posedge clk) disable iff (reset_i)
        !(fill_active_i && line_drawing_i)
    );

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset_i)
        vram_wr_o |-> (vram_addr_o < FB_SIZE)
    );

endmodule

// File: src/raster_pkg.sv
package raster_pkg;

    // field widths of the command word and the framebuffer
    localparam int COORD_W = 12;
    localparam int ADDR_W  = 16;
    localparam int PIXEL_W = 16;
    localparam int CMD_W   = 16;
    localparam int OP_W    = 4;
    localparam int ARG_W   = 12;

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic        [ADDR_W-1:0]  addr_t;

    // ARGB4444, alpha in the top nibble
    typedef logic        [PIXEL_W-1:0] pixel_t;

    // opcode lives in cmd[15:12], codes 8..15 are ignored
    typedef enum logic [OP_W-1:0] {
        OP_SET_X0     = 4'd0,
        OP_SET_Y0     = 4'd1,
        OP_SET_X1     = 4'd2,
        OP_SET_Y1     = 4'd3,
        OP_SET_COLOR  = 4'd4,
        OP_CLEAR      = 4'd5,
        OP_DRAW_LINE  = 4'd6,
        OP_SWAP       = 4'd7
    } op_e;

endpackage

// File: src/raster_top.sv
`timescale 1ns/1ps

module raster_top #(
    parameter int FB_WIDTH  = 128,
    parameter int FB_HEIGHT = 128
) (
    input  logic                          clk,
    input  logic                          reset_i,

    // command stream
    input  logic                          cmd_valid_i,
    output logic                          cmd_ready_o,
    input  logic [raster_pkg::CMD_W-1:0]  cmd_data_i,

    // framebuffer write port, no acknowledge
    output logic                          vram_wr_o,
    output raster_pkg::addr_t             vram_addr_o,
    output raster_pkg::pixel_t            vram_data_o,

    output logic                          swap_o
);
    import raster_pkg::*;

    logic   fill_start;
    logic   fill_active;
    logic   fill_done;
    addr_t  fill_addr;

    logic   line_start;
    logic   line_drawing;
    logic   line_done;
    coord_t line_x;
    coord_t line_y;

    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    pixel_t color;

    cmd_sequencer cmd_sequencer_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_data_i   (cmd_data_i),
        .fill_done_i  (fill_done),
        .line_done_i  (line_done),
        .fill_start_o (fill_start),
        .line_start_o (line_start),
        .x0_o         (x0),
        .y0_o         (y0),
        .x1_o         (x1),
        .y1_o         (y1),
        .color_o      (color),
        .swap_o       (swap_o)
    );

    fill_counter #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) fill_counter_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (fill_start),
        .addr_o   (fill_addr),
        .active_o (fill_active),
        .done_o   (fill_done)
    );

    line_stepper line_stepper_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (line_start),
        .x0_i      (x0),
        .y0_i      (y0),
        .x1_i      (x1),
        .y1_i      (y1),
        .x_o       (line_x),
        .y_o       (line_y),
        .drawing_o (line_drawing),
        .done_o    (line_done)
    );

    pixel_writer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) pixel_writer_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .fill_active_i  (fill_active),
        .fill_addr_i    (fill_addr),
        .line_drawing_i (line_drawing),
        .line_x_i       (line_x),
        .line_y_i       (line_y),
        .color_i        (color),
        .vram_wr_o      (vram_wr_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_o    (vram_data_o)
    );

endmodule

// File: include/raster_model.svh
`ifndef RASTER_MODEL_SVH
`define RASTER_MODEL_SVH

// registers mirrored from the command stream
int     m_x0;
int     m_y0;
int     m_x1;
int     m_y1;
pixel_t m_color;

// expected VRAM writes as {follows previous write, address, data}
logic [ADDR_W+PIXEL_W:0] exp_q[$];

// model_fb is what should be in VRAM, shadow_fb is what the DUT wrote
pixel_t model_fb[FB_SIZE];
pixel_t shadow_fb[FB_SIZE];

function automatic void push_write(int addr, pixel_t data, logic follows);
    exp_q.push_back({follows, ADDR_W'(addr), data});
    model_fb[addr] = data;
endfunction

// clear sweeps every address, back to back
function automatic void model_clear();
    for (int a = 0; a < FB_SIZE; a++) begin
        push_write(a, m_color, a != 0);
    end
endfunction

// plain Bresenham, only on-screen points are written
function automatic void model_line();
    int  x;
    int  y;
    int  dx;
    int  dy;
    int  sx;
    int  sy;
    int  err;
    int  e2;
    logic last;
    x    = m_x0;
    y    = m_y0;
    dx   = (m_x1 > m_x0) ? m_x1 - m_x0 : m_x0 - m_x1;
    dy   = (m_y1 > m_y0) ? m_y0 - m_y1 : m_y1 - m_y0;
    sx   = (m_x0 < m_x1) ? 1 : -1;
    sy   = (m_y0 < m_y1) ? 1 : -1;
    err  = dx + dy;
    last = 1'b0;
    while (!last) begin
        if (x >= 0 && x < FB_W && y >= 0 && y < FB_H) begin
            push_write(y * FB_W + x, m_color, 1'b0);
        end
        last = (x == m_x1) && (y == m_y1);
        e2   = 2 * err;
        if (e2 >= dy) begin
            err = err + dy;
            x   = x + sx;
        end
        if (e2 <= dx) begin
            err = err + dx;
            y   = y + sy;
        end
    end
endfunction

function automatic void model_apply(logic [OP_W-1:0] op, logic [ARG_W-1:0] arg);
    case (op)
        OP_SET_X0:    m_x0 = int'($signed(arg));
        OP_SET_Y0:    m_y0 = int'($signed(arg));
        OP_SET_X1:    m_x1 = int'($signed(arg));
        OP_SET_Y1:    m_y1 = int'($signed(arg));
        OP_SET_COLOR: m_color = {4'hF, arg};
        OP_CLEAR:     model_clear();
        OP_DRAW_LINE: model_line();
        default: ;
    endcase
endfunction

`endif

// File: test/tb_raster.sv
`timescale 1ns/1ps

module tb_raster;
    import raster_pkg::*;

    localparam int FB_W          = 16;
    localparam int FB_H          = 12;
    localparam int FB_SIZE       = FB_W * FB_H;
    localparam int READY_TIMEOUT = 1000;

    logic             clk;
    logic             reset;
    logic             cmd_valid;
    logic             cmd_ready;
    logic [CMD_W-1:0] cmd_data;
    logic             vram_wr;
    addr_t            vram_addr;
    pixel_t           vram_data;
    logic             swap;

    logic [31:0]             lfsr;
    logic [ADDR_W+PIXEL_W:0] exp_entry;
    logic                    prev_wr;

    `include "raster_model.svh"

    raster_top #(
        .FB_WIDTH  (FB_W),
        .FB_HEIGHT (FB_H)
    ) raster_top_i (
        .clk         (clk),
        .reset_i     (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .cmd_data_i  (cmd_data),
        .vram_wr_o   (vram_wr),
        .vram_addr_o (vram_addr),
        .vram_data_o (vram_data),
        .swap_o      (swap)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // fibonacci LFSR with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int rand_range(int lo, int span);
        return lo + int'(take_bits(5)) % span;
    endfunction

    task automatic send_cmd(input logic [OP_W-1:0] op, input logic [ARG_W-1:0] arg);
        int gap;
        int waited;
        gap = int'(take_bits(2));
        repeat (gap) begin
            @(negedge clk);
            assert (swap == 1'b0) else
                report_failure("error swap_o got 0x1 expected 0x0");
        end
        cmd_valid = 1'b1;
        cmd_data  = {op, arg};
        waited    = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            assert (swap == 1'b0) else
                report_failure("error swap_o got 0x1 expected 0x0");
            waited++;
            if (waited > READY_TIMEOUT) begin
                report_failure("timeout while waiting for cmd_ready_o to rise");
            end
        end
        // the handshake completes on the edge before this one
        @(negedge clk);
        cmd_valid = 1'b0;
        assert (swap == (op == OP_SWAP)) else
            report_failure($sformatf("error swap_o got 0x%0h expected 0x%0h",
                                     swap, op == OP_SWAP));
        model_apply(op, arg);
    endtask

    task automatic line_cmds(input int x0, input int y0, input int x1, input int y1);
        send_cmd(OP_SET_X0, ARG_W'(x0));
        send_cmd(OP_SET_Y0, ARG_W'(y0));
        send_cmd(OP_SET_X1, ARG_W'(x1));
        send_cmd(OP_SET_Y1, ARG_W'(y1));
        send_cmd(OP_DRAW_LINE, ARG_W'(0));
    endtask

    // every write is checked against the head of the expected queue
    always @(negedge clk) begin
        if (!reset) begin
            if (vram_wr) begin
                assert (exp_q.size() > 0) else
                    report_failure("a VRAM write appeared that the model did not expect");
                exp_entry = exp_q.pop_front();
                assert (!exp_entry[ADDR_W+PIXEL_W] || prev_wr) else
                    report_failure("clear writes were not on consecutive cycles");
                assert (vram_addr == exp_entry[ADDR_W+PIXEL_W-1:PIXEL_W]) else
                    report_failure($sformatf("error vram_addr_o got 0x%0h expected 0x%0h",
                        vram_addr, exp_entry[ADDR_W+PIXEL_W-1:PIXEL_W]));
                assert (vram_data == exp_entry[PIXEL_W-1:0]) else
                    report_failure($sformatf("error vram_data_o got 0x%0h expected 0x%0h",
                        vram_data, exp_entry[PIXEL_W-1:0]));
                shadow_fb[vram_addr] = vram_data;
            end
            prev_wr = vram_wr;
            assert (!cmd_ready || exp_q.size() == 0) else
                report_failure("cmd_ready_o rose before the last write of an operation");
        end
    end

    initial begin
        int          waited;
        logic [3:0]  v;
        logic [OP_W-1:0] op;
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        lfsr      = 32'h4de8;
        prev_wr   = 1'b0;
        m_x0      = 0;
        m_y0      = 0;
        m_x1      = 0;
        m_y1      = 0;
        m_color   = '0;
        for (int i = 0; i < FB_SIZE; i++) begin
            model_fb[i]  = '0;
            shadow_fb[i] = '0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (cmd_ready == 1'b1 && vram_wr == 1'b0 && swap == 1'b0) else
            report_failure("outputs are not in their idle state after reset");

        // SET commands and ignored opcodes produce no writes
        repeat (24) begin
            v = 4'(take_bits(4));
            op = (v >= 5 && v < 8) ? v + 4'd8 : v;
            send_cmd(op, ARG_W'(take_bits(12)));
        end

        send_cmd(OP_SET_COLOR, ARG_W'(take_bits(12)));
        send_cmd(OP_CLEAR, ARG_W'(0));

        // on-screen lines
        repeat (24) begin
            line_cmds(rand_range(0, FB_W), rand_range(0, FB_H),
                      rand_range(0, FB_W), rand_range(0, FB_H));
        end
        send_cmd(OP_SWAP, ARG_W'(take_bits(12)));

        // partly clipped lines and a couple fully off-screen
        repeat (24) begin
            line_cmds(rand_range(-4, 25), rand_range(-4, 25),
                      rand_range(-4, 25), rand_range(-4, 25));
        end
        line_cmds(18, -3, 20, -1);
        line_cmds(-4, 5, -1, 9);
        send_cmd(OP_SWAP, ARG_W'(take_bits(12)));

        // mixed stream
        repeat (300) begin
            op = OP_W'(take_bits(3));
            if (op <= OP_SET_Y1) begin
                send_cmd(op, ARG_W'(rand_range(-4, 25)));
            end else begin
                send_cmd(op, ARG_W'(take_bits(12)));
            end
        end

        waited = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            assert (swap == 1'b0) else
                report_failure("error swap_o got 0x1 expected 0x0");
            waited++;
            if (waited > READY_TIMEOUT) begin
                report_failure("timeout while waiting for the last operation to finish");
            end
        end
        @(negedge clk);
        assert (exp_q.size() == 0) else
            report_failure("expected VRAM writes are still outstanding at the end");
        for (int i = 0; i < FB_SIZE; i++) begin
            assert (shadow_fb[i] == model_fb[i]) else
                report_failure($sformatf("error shadow_fb[%0d] got 0x%0h expected 0x%0h",
                                         i, shadow_fb[i], model_fb[i]));
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule
